// File: logic/cpuTypesPkg.sv
package cpuTypesPkg;

  // Datapath and register index widths.
  localparam int dataWidth    = 32;
  localparam int regAddrWidth = 5;

  // Data memory is word addressed.
  localparam int memDepth     = 64;
  localparam int memAddrWidth = 6;

  // Primary opcodes in bits 31 to 26.
  typedef enum logic [5:0] {
    OP_RTYPE = 6'd0,
    OP_ADDI  = 6'd8,
    OP_LUI   = 6'd15,
    OP_LW    = 6'd35,
    OP_SW    = 6'd43
  } opcodeT;

  // Function codes for R-type instructions.
  typedef enum logic [5:0] {
    FN_ADD = 6'd32,
    FN_SUB = 6'd34,
    FN_AND = 6'd36,
    FN_OR  = 6'd37,
    FN_SLT = 6'd42
  } functT;

  // Operation selected by decode for the ALU.
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT,
    ALU_LUI
  } aluOpT;

endpackage

// File: logic/executeStage.sv
`timescale 1ns/1ps

module executeStage (
  input  logic                                instrValid,
  input  logic [31:0]                         instr,
  input  logic [cpuTypesPkg::dataWidth-1:0]    rdata1,
  input  logic [cpuTypesPkg::dataWidth-1:0]    rdata2,
  output logic [cpuTypesPkg::regAddrWidth-1:0] raddr1,
  output logic [cpuTypesPkg::regAddrWidth-1:0] raddr2,
  input  logic                                memFwdValid,
  input  logic [cpuTypesPkg::regAddrWidth-1:0] memFwdReg,
  input  logic [cpuTypesPkg::dataWidth-1:0]    memFwdData,
  input  logic                                wbFwdValid,
  input  logic [cpuTypesPkg::regAddrWidth-1:0] wbFwdReg,
  input  logic [cpuTypesPkg::dataWidth-1:0]    wbFwdData,
  output logic                                exValid,
  output logic                                exWen,
  output logic                                exMemRead,
  output logic                                exMemWrite,
  output logic [cpuTypesPkg::regAddrWidth-1:0] exDest,
  output logic [cpuTypesPkg::dataWidth-1:0]    exResult,
  output logic [cpuTypesPkg::dataWidth-1:0]    exStoreData
);
  import cpuTypesPkg::*;

  logic                    decWen;
  logic                    decMemRead;
  logic                    decMemWrite;
  logic                    useImm;
  logic                    destIsRd;
  aluOpT                   aluOp;
  logic [regAddrWidth-1:0] rd;
  logic [dataWidth-1:0]    immExt;
  logic [dataWidth-1:0]    rsVal;
  logic [dataWidth-1:0]    rtVal;
  logic [dataWidth-1:0]    opB;

  assign raddr1 = instr[25:21];
  assign raddr2 = instr[20:16];
  assign rd     = instr[15:11];
  assign immExt = {{(dataWidth-16){instr[15]}}, instr[15:0]};

  // Main decoder. Unknown encodings fall through as no-ops.
  always_comb
  begin
    decWen      = 1'b0;
    decMemRead  = 1'b0;
    decMemWrite = 1'b0;
    useImm      = 1'b1;
    destIsRd    = 1'b0;
    aluOp       = ALU_ADD;
    case (opcodeT'(instr[31:26]))
      OP_RTYPE:
      begin
        useImm   = 1'b0;
        destIsRd = 1'b1;
        decWen   = 1'b1;
        case (functT'(instr[5:0]))
          FN_ADD:  aluOp = ALU_ADD;
          FN_SUB:  aluOp = ALU_SUB;
          FN_AND:  aluOp = ALU_AND;
          FN_OR:   aluOp = ALU_OR;
          FN_SLT:  aluOp = ALU_SLT;
          default: decWen = 1'b0;
        endcase
      end
      OP_ADDI: decWen = 1'b1;
      OP_LUI:
      begin
        decWen = 1'b1;
        aluOp  = ALU_LUI;
      end
      OP_LW:
      begin
        decWen     = 1'b1;
        decMemRead = 1'b1;
      end
      OP_SW:   decMemWrite = 1'b1;
      default: decWen = 1'b0;
    endcase
  end

  // MEM stage wins over WB, and WB wins over the register file.
  function automatic logic [dataWidth-1:0] pickOperand(
    input logic [regAddrWidth-1:0] src,
    input logic [dataWidth-1:0]    rfVal
  );
    if (memFwdValid && memFwdReg != '0 && memFwdReg == src)
      return memFwdData;
    else if (wbFwdValid && wbFwdReg != '0 && wbFwdReg == src)
      return wbFwdData;
    else
      return rfVal;
  endfunction

  assign rsVal = pickOperand(raddr1, rdata1);
  assign rtVal = pickOperand(raddr2, rdata2);
  assign opB   = useImm ? immExt : rtVal;

  always_comb
  begin
    case (aluOp)
      ALU_SUB: exResult = rsVal - opB;
      ALU_AND: exResult = rsVal & opB;
      ALU_OR:  exResult = rsVal | opB;
      ALU_SLT: exResult = {{(dataWidth-1){1'b0}}, $signed(rsVal) < $signed(opB)};
      ALU_LUI: exResult = {instr[15:0], 16'h0000};
      default: exResult = rsVal + opB;
    endcase
  end

  assign exDest      = destIsRd ? rd : raddr2;
  assign exStoreData = rtVal;
  assign exValid     = instrValid;
  // A write to r0 is dropped here, so it never reaches writeback.
  assign exWen       = instrValid & decWen & (exDest != '0);
  assign exMemRead   = instrValid & decMemRead;
  assign exMemWrite  = instrValid & decMemWrite;

endmodule

// File: logic/memStage.sv
`timescale 1ns/1ps

module memStage (
  input  logic                                CLK,
  input  logic                                nRST,
  input  logic                                memValid,
  input  logic                                memWen,
  input  logic                                memMemRead,
  input  logic                                memMemWrite,
  input  logic [cpuTypesPkg::regAddrWidth-1:0] memDest,
  input  logic [cpuTypesPkg::dataWidth-1:0]    memResult,
  input  logic [cpuTypesPkg::dataWidth-1:0]    memStoreData,
  output logic [cpuTypesPkg::dataWidth-1:0]    memFwdData,
  output logic                                wbValid,
  output logic                                wbWen,
  output logic [cpuTypesPkg::regAddrWidth-1:0] wbReg,
  output logic [cpuTypesPkg::dataWidth-1:0]    wbData
);
  import cpuTypesPkg::*;

  logic [dataWidth-1:0]    dmem [memDepth];
  logic [memAddrWidth-1:0] wordAddr;

  // Byte address to word index.
  assign wordAddr   = memResult[memAddrWidth+1:2];
  assign memFwdData = memMemRead ? dmem[wordAddr] : memResult;

  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
    begin
      for (int i = 0; i < memDepth; i++)
        dmem[i] <= '0;
    end
    else if (memValid && memMemWrite)
    begin
      dmem[wordAddr] <= memStoreData;
    end
  end

  // Stores never set wbValid.
  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
    begin
      wbValid <= 1'b0;
      wbWen   <= 1'b0;
    end
    else
    begin
      wbValid <= memValid & memWen;
      wbWen   <= memWen;
    end
  end

  always_ff @(posedge CLK)
  begin
    wbReg  <= memDest;
    wbData <= memFwdData;
  end

endmodule

// File: logic/pipeRegExMem.sv
`timescale 1ns/1ps

module pipeRegExMem (
  input  logic                                CLK,
  input  logic                                nRST,
  input  logic                                flush,
  input  logic                                exValid,
  input  logic                                exWen,
  input  logic                                exMemRead,
  input  logic                                exMemWrite,
  input  logic [cpuTypesPkg::regAddrWidth-1:0] exDest,
  input  logic [cpuTypesPkg::dataWidth-1:0]    exResult,
  input  logic [cpuTypesPkg::dataWidth-1:0]    exStoreData,
  output logic                                memValid,
  output logic                                memWen,
  output logic                                memMemRead,
  output logic                                memMemWrite,
  output logic [cpuTypesPkg::regAddrWidth-1:0] memDest,
  output logic [cpuTypesPkg::dataWidth-1:0]    memResult,
  output logic [cpuTypesPkg::dataWidth-1:0]    memStoreData
);

  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
    begin
      memValid     <= 1'b0;
      memWen       <= 1'b0;
      memMemRead   <= 1'b0;
      memMemWrite  <= 1'b0;
      memDest      <= '0;
      memResult    <= '0;
      memStoreData <= '0;
    end
    else if (flush)
    begin
      // Kill the incoming instruction. Data fields hold.
      memValid    <= 1'b0;
      memWen      <= 1'b0;
      memMemRead  <= 1'b0;
      memMemWrite <= 1'b0;
    end
    else
    begin
      memValid     <= exValid;
      memWen       <= exWen;
      memMemRead   <= exMemRead;
      memMemWrite  <= exMemWrite;
      memDest      <= exDest;
      memResult    <= exResult;
      memStoreData <= exStoreData;
    end
  end

endmodule

// File: logic/pipeSlice.sv
`timescale 1ns/1ps

module pipeSlice (
  input  logic                                CLK,
  input  logic                                nRST,
  input  logic                                instrValid,
  input  logic                                flush,
  input  logic [31:0]                         instr,
  output logic                                wbValid,
  output logic [cpuTypesPkg::regAddrWidth-1:0] wbReg,
  output logic [cpuTypesPkg::dataWidth-1:0]    wbData
);
  import cpuTypesPkg::*;

  logic [regAddrWidth-1:0] raddr1, raddr2;
  logic [dataWidth-1:0]    rdata1, rdata2;
  logic                    exValid, exWen, exMemRead, exMemWrite;
  logic [regAddrWidth-1:0] exDest;
  logic [dataWidth-1:0]    exResult, exStoreData;
  logic                    memValid, memWen, memMemRead, memMemWrite;
  logic [regAddrWidth-1:0] memDest;
  logic [dataWidth-1:0]    memResult, memStoreData, memFwdData;
  logic                    wbWen;
  logic                    memWrites, wbWrites;

  // A stage forwards only when it is valid and writes a register.
  assign memWrites = memValid & memWen;
  assign wbWrites  = wbValid & wbWen;

  regFile u_regFile (
    .CLK(CLK), .nRST(nRST),
    .wen(wbWrites), .waddr(wbReg), .wdata(wbData),
    .raddr1(raddr1), .raddr2(raddr2),
    .rdata1(rdata1), .rdata2(rdata2)
  );

  executeStage u_executeStage (
    .instrValid(instrValid), .instr(instr),
    .rdata1(rdata1), .rdata2(rdata2), .raddr1(raddr1), .raddr2(raddr2),
    .memFwdValid(memWrites), .memFwdReg(memDest), .memFwdData(memFwdData),
    .wbFwdValid(wbWrites), .wbFwdReg(wbReg), .wbFwdData(wbData),
    .exValid(exValid), .exWen(exWen), .exMemRead(exMemRead), .exMemWrite(exMemWrite),
    .exDest(exDest), .exResult(exResult), .exStoreData(exStoreData)
  );

  pipeRegExMem u_pipeRegExMem (
    .CLK(CLK), .nRST(nRST), .flush(flush),
    .exValid(exValid), .exWen(exWen), .exMemRead(exMemRead), .exMemWrite(exMemWrite),
    .exDest(exDest), .exResult(exResult), .exStoreData(exStoreData),
    .memValid(memValid), .memWen(memWen), .memMemRead(memMemRead),
    .memMemWrite(memMemWrite), .memDest(memDest), .memResult(memResult),
    .memStoreData(memStoreData)
  );

  memStage u_memStage (
    .CLK(CLK), .nRST(nRST),
    .memValid(memValid), .memWen(memWen), .memMemRead(memMemRead),
    .memMemWrite(memMemWrite), .memDest(memDest), .memResult(memResult),
    .memStoreData(memStoreData), .memFwdData(memFwdData),
    .wbValid(wbValid), .wbWen(wbWen), .wbReg(wbReg), .wbData(wbData)
  );

endmodule

// File: logic/regFile.sv
`timescale 1ns/1ps

module regFile (
  input  logic                                CLK,
  input  logic                                nRST,
  input  logic                                wen,
  input  logic [cpuTypesPkg::regAddrWidth-1:0] waddr,
  input  logic [cpuTypesPkg::dataWidth-1:0]    wdata,
  input  logic [cpuTypesPkg::regAddrWidth-1:0] raddr1,
  input  logic [cpuTypesPkg::regAddrWidth-1:0] raddr2,
  output logic [cpuTypesPkg::dataWidth-1:0]    rdata1,
  output logic [cpuTypesPkg::dataWidth-1:0]    rdata2
);
  import cpuTypesPkg::*;

  logic [dataWidth-1:0] regs [2**regAddrWidth];

  // Register 0 is never written.
  always_ff @(posedge CLK or negedge nRST)
  begin
    if (!nRST)
    begin
      for (int i = 0; i < 2**regAddrWidth; i++)
        regs[i] <= '0;
    end
    else if (wen && waddr != '0)
    begin
      regs[waddr] <= wdata;
    end
  end

  // Write-through so a same-cycle read sees the new value.
  assign rdata1 = (raddr1 == '0) ? '0 :
                  (wen && waddr == raddr1) ? wdata : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 :
                  (wen && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

// File: run.sh
#!/bin/sh
# Builds and runs the pipeline testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module pipeSliceTb -f src.f -o pipeSliceSim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/pipeSliceSim +verilator+error+limit+1000 > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -qx "Verification passed" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// File: src.f
logic/cpuTypesPkg.sv
logic/regFile.sv
logic/executeStage.sv
logic/pipeRegExMem.sv
logic/memStage.sv
logic/pipeSlice.sv
test/clockGen.sv
test/pipeSlice_props.sv
test/pipeSliceTb.sv

// File: test/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
  parameter int period = 8
) (
  output logic CLK
);

  initial
  begin
    CLK = 1'b0;
  end

  // Toggle every half period.
  always #(period / 2) CLK = ~CLK;

endmodule

// File: test/pipeSliceTb.sv
`timescale 1ns/1ps

module pipeSliceTb;
  import cpuTypesPkg::*;

  localparam int resetCycles    = 10;
  localparam int directedSlots  = 60;
  localparam int randomCount    = 400;
  localparam int drainCycles    = 10;
  localparam int watchdogCycles = resetCycles + directedSlots + randomCount * 3 + drainCycles + 50;

  logic                    CLK;
  logic                    nRST;
  logic                    instrValid;
  logic                    flush;
  logic [31:0]             instr;
  logic                    wbValid;
  logic [regAddrWidth-1:0] wbReg;
  logic [dataWidth-1:0]    wbData;

  logic [dataWidth-1:0] modelRegs [32];
  logic [dataWidth-1:0] modelMem [memDepth];
  logic [31:0]          lfsrState = 32'h8a40;
  int                   cycle = 0;
  int                   errorCount = 0;

  // Expected writebacks in program order.
  logic [4:0]  expRegQ [$];
  logic [31:0] expDataQ [$];
  int          expCycleQ [$];
  string       expNameQ [$];

  clockGen #(.period(8)) clkGen (.CLK(CLK));

  pipeSlice dut (
    .CLK(CLK), .nRST(nRST), .instrValid(instrValid), .flush(flush), .instr(instr),
    .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData)
  );

  always @(posedge CLK) cycle <= cycle + 1;

  // Taps 32, 22, 2 and 1.
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsrState = lfsrNext(lfsrState);
      v = {v[30:0], lfsrState[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] rType(input functT fn, input logic [4:0] rd, rs, rt);
    return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] iType(input opcodeT op, input logic [4:0] rt, rs,
                                        input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  // Executes one instruction on the model state and returns 1 when a register is written.
  function automatic bit refExecute(input logic [31:0] ins, output logic [4:0] dReg,
                                    output logic [31:0] dData);
    aluOpT       aop;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    bit          writes;
    a      = modelRegs[ins[25:21]];
    b      = {{16{ins[15]}}, ins[15:0]};
    aop    = ALU_ADD;
    writes = 1'b1;
    dReg   = ins[20:16];
    case (opcodeT'(ins[31:26]))
      OP_RTYPE:
      begin
        b    = modelRegs[ins[20:16]];
        dReg = ins[15:11];
        case (functT'(ins[5:0]))
          FN_SUB:  aop = ALU_SUB;
          FN_AND:  aop = ALU_AND;
          FN_OR:   aop = ALU_OR;
          FN_SLT:  aop = ALU_SLT;
          default: aop = ALU_ADD;
        endcase
      end
      OP_LUI:  aop = ALU_LUI;
      OP_SW:   writes = 1'b0;
      default: aop = ALU_ADD;
    endcase
    case (aop)
      ALU_SUB: res = a - b;
      ALU_AND: res = a & b;
      ALU_OR:  res = a | b;
      ALU_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ALU_LUI: res = {ins[15:0], 16'h0000};
      default: res = a + b;
    endcase
    if (opcodeT'(ins[31:26]) == OP_SW)
      modelMem[res[7:2]] = modelRegs[ins[20:16]];
    if (opcodeT'(ins[31:26]) == OP_LW)
      res = modelMem[res[7:2]];
    dData = res;
    if (writes && dReg != '0)
      modelRegs[dReg] = res;
    return writes && dReg != '0;
  endfunction

  // Registers r0 to r7 only. Memory accesses use r0 as the base.
  function automatic logic [31:0] randomInstr();
    logic [31:0] kind;
    logic [31:0] rd;
    logic [31:0] rs;
    logic [31:0] rt;
    logic [31:0] imm;
    logic [31:0] addr;
    kind = randBits(4);
    rd   = randBits(3);
    rs   = randBits(3);
    rt   = randBits(3);
    imm  = randBits(16);
    addr = randBits(6);
    case (kind[3:0])
      4'd0:               return rType(FN_ADD, rd[4:0], rs[4:0], rt[4:0]);
      4'd1:               return rType(FN_SUB, rd[4:0], rs[4:0], rt[4:0]);
      4'd2:               return rType(FN_AND, rd[4:0], rs[4:0], rt[4:0]);
      4'd3:               return rType(FN_OR, rd[4:0], rs[4:0], rt[4:0]);
      4'd4:               return rType(FN_SLT, rd[4:0], rs[4:0], rt[4:0]);
      4'd5, 4'd6, 4'd7:   return iType(OP_ADDI, rt[4:0], rs[4:0], imm[15:0]);
      4'd8, 4'd9:         return iType(OP_LUI, rt[4:0], 5'd0, imm[15:0]);
      4'd10, 4'd11, 4'd12: return iType(OP_LW, rt[4:0], 5'd0, {8'd0, addr[5:0], 2'b00});
      default:            return iType(OP_SW, rt[4:0], 5'd0, {8'd0, addr[5:0], 2'b00});
    endcase
  endfunction

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (expected !== actual)
    begin
      errorCount++;
      $display("ERR %s expected %h actual %h", name, expected, actual);
    end
  endtask

  // The result is due two cycles after the edge that samples the instruction.
  task automatic issue(input logic [31:0] ins, input logic fl, input string name);
    logic [4:0]  dReg;
    logic [31:0] dData;
    bit          writes;
    @(posedge CLK);
    #1;
    instrValid = 1'b1;
    instr      = ins;
    flush      = fl;
    if (!fl)
    begin
      writes = refExecute(ins, dReg, dData);
      if (writes)
      begin
        expRegQ.push_back(dReg);
        expDataQ.push_back(dData);
        expCycleQ.push_back(cycle + 2);
        expNameQ.push_back(name);
      end
    end
  endtask

  task automatic idle(input int n);
    repeat (n)
    begin
      @(posedge CLK);
      #1;
      instrValid = 1'b0;
      flush      = 1'b0;
    end
  endtask

  always @(negedge CLK)
  begin
    string       popName;
    logic [4:0]  expReg;
    logic [31:0] expData;
    int          expCycle;
    if (nRST && wbValid)
    begin
      if (expRegQ.size() == 0)
      begin
        errorCount++;
        $display("Writeback to r%0d arrived with no instruction outstanding", wbReg);
      end
      else
      begin
        popName  = expNameQ.pop_front();
        expReg   = expRegQ.pop_front();
        expData  = expDataQ.pop_front();
        expCycle = expCycleQ.pop_front();
        checkValue({popName, " reg"}, {27'd0, expReg}, {27'd0, wbReg});
        checkValue({popName, " data"}, expData, wbData);
        checkValue({popName, " latency"}, expCycle, cycle);
      end
    end
  end

  initial
  begin
    repeat (watchdogCycles) @(posedge CLK);
    $display("Timeout after %0d cycles, the run did not finish", watchdogCycles);
    $display("Verification failed");
    $finish;
  end

  initial
  begin
    logic [31:0] ins;
    logic [31:0] v;
    nRST       = 1'b0;
    // A valid instruction held during reset must never enter the pipeline.
    instrValid = 1'b1;
    flush      = 1'b0;
    instr      = iType(OP_ADDI, 5'd1, 5'd0, 16'h00ff);
    for (int i = 0; i < 32; i++)
      modelRegs[i] = '0;
    for (int i = 0; i < memDepth; i++)
      modelMem[i] = '0;
    repeat (resetCycles) @(posedge CLK);
    #1;
    nRST       = 1'b1;
    instrValid = 1'b0;

    // Independent ALU operations, spaced so no forwarding is needed.
    issue(iType(OP_ADDI, 5'd1, 5'd0, 16'h1234), 1'b0, "alu");
    issue(iType(OP_ADDI, 5'd2, 5'd0, 16'hfffb), 1'b0, "alu");
    issue(iType(OP_LUI, 5'd3, 5'd0, 16'habcd), 1'b0, "alu");
    idle(3);
    issue(rType(FN_ADD, 5'd4, 5'd1, 5'd2), 1'b0, "alu");
    issue(rType(FN_SUB, 5'd5, 5'd1, 5'd2), 1'b0, "alu");
    issue(rType(FN_AND, 5'd6, 5'd1, 5'd3), 1'b0, "alu");
    issue(rType(FN_OR, 5'd7, 5'd2, 5'd3), 1'b0, "alu");
    issue(rType(FN_SLT, 5'd1, 5'd2, 5'd1), 1'b0, "alu");
    idle(3);
    // Dependencies at distance 1 and 2.
    issue(iType(OP_ADDI, 5'd1, 5'd1, 16'h0007), 1'b0, "forward");
    issue(rType(FN_ADD, 5'd2, 5'd1, 5'd1), 1'b0, "forward");
    issue(rType(FN_SUB, 5'd3, 5'd2, 5'd1), 1'b0, "forward");
    issue(rType(FN_SLT, 5'd4, 5'd3, 5'd2), 1'b0, "forward");
    issue(rType(FN_OR, 5'd5, 5'd4, 5'd3), 1'b0, "forward");
    idle(3);
    // Store then load of one word, with a use right after the load.
    issue(iType(OP_ADDI, 5'd1, 5'd0, 16'h0077), 1'b0, "memory");
    issue(iType(OP_SW, 5'd1, 5'd0, 16'h0008), 1'b0, "memory");
    issue(iType(OP_LW, 5'd2, 5'd0, 16'h0008), 1'b0, "memory");
    issue(rType(FN_ADD, 5'd3, 5'd2, 5'd2), 1'b0, "memory");
    issue(iType(OP_SW, 5'd3, 5'd0, 16'h00fc), 1'b0, "memory");
    issue(iType(OP_LW, 5'd4, 5'd0, 16'h00fc), 1'b0, "memory");
    idle(3);
    issue(iType(OP_ADDI, 5'd0, 5'd0, 16'h0055), 1'b0, "r0");
    issue(iType(OP_LW, 5'd0, 5'd0, 16'h0008), 1'b0, "r0");
    issue(rType(FN_ADD, 5'd5, 5'd0, 5'd0), 1'b0, "r0");
    idle(3);
    // Flushed ALU op and flushed store leave no trace.
    issue(iType(OP_ADDI, 5'd1, 5'd0, 16'h0005), 1'b0, "flush");
    issue(iType(OP_ADDI, 5'd1, 5'd0, 16'h0009), 1'b1, "flush");
    issue(rType(FN_ADD, 5'd2, 5'd1, 5'd1), 1'b0, "flush");
    issue(iType(OP_SW, 5'd2, 5'd0, 16'h0008), 1'b1, "flush");
    issue(iType(OP_LW, 5'd3, 5'd0, 16'h0008), 1'b0, "flush");
    idle(3);

    for (int i = 0; i < randomCount; i++)
    begin
      ins = randomInstr();
      v = randBits(4);
      issue(ins, v[3:0] == 4'd0, "random");
      v = randBits(2);
      idle(v[1:0] == 2'd3 ? 2 : (v[1:0] == 2'd2 ? 1 : 0));
    end
    idle(drainCycles);

    if (expRegQ.size() != 0)
    begin
      errorCount++;
      $display("%0d expected writebacks never arrived", expRegQ.size());
    end
    if (dut.u_pipeRegExMem.props.violations != 0)
    begin
      errorCount += dut.u_pipeRegExMem.props.violations;
      $display("Pipeline register assertions failed %0d times",
               dut.u_pipeRegExMem.props.violations);
    end
    $display("Errors: %0d", errorCount);
    if (errorCount == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

// File: test/pipeSlice_props.sv
`timescale 1ns/1ps

module pipeRegExMemProps (
  input logic CLK,
  input logic nRST,
  input logic flush,
  input logic memValid,
  input logic memMemRead,
  input logic memMemWrite
);

  int violations = 0;

  // The stage stays empty while reset is held.
  resetEmpty: assert property (@(posedge CLK) !nRST |-> !memValid)
    else
    begin
      violations++;
      $error("memValid high while nRST is low");
    end

  // A flushed capture leaves no valid instruction behind.
  flushKills: assert property (@(posedge CLK) disable iff (!nRST) flush |=> !memValid)
    else
    begin
      violations++;
      $error("memValid high in the cycle after a flush");
    end

  oneMemOp: assert property (@(posedge CLK) disable iff (!nRST) !(memMemRead && memMemWrite))
    else
    begin
      violations++;
      $error("memMemRead and memMemWrite both high");
    end

endmodule

bind pipeRegExMem pipeRegExMemProps props (
  .CLK(CLK), .nRST(nRST), .flush(flush), .memValid(memValid),
  .memMemRead(memMemRead), .memMemWrite(memMemWrite)
);
